/* src/intr_pkg.sv */
// intr_pkg
// Interrupt level types, the level to mask group table and the
// command word that the control FSM sends to the datapath
// level 0 is the highest priority and cannot be masked

package intr_pkg;

	localparam int NUM_LEVELS = 32;
	localparam int CHAN_BASE  = 12;	// channel 0 lands on level 12
	localparam int NUM_BOUNDS = 9;	// mask bits that accept can clear

	typedef logic [4:0] level_t;	// level number, also the vector
	typedef logic [NUM_LEVELS-1:0] req_vec_t;	// bit n = level n
	typedef logic [9:0] mask_t;
	typedef logic [15:0] src_vec_t;
	typedef logic [3:0] chan_t;
	typedef logic [3:0] grp_t;	// index into mask_t

	localparam grp_t NO_GROUP = 4'hf;	// level is never masked

	// which RM bit gates each level
	localparam grp_t MASK_GROUP [NUM_LEVELS] = '{
		NO_GROUP,	// 0, nmi
		4'd0, 4'd1, 4'd2, 4'd3,	// 1..4 one bit each
		4'd4, 4'd4, 4'd4, 4'd4, 4'd4, 4'd4, 4'd4,	// 5..11
		4'd5, 4'd5,	// 12..13
		4'd6, 4'd6,	// 14..15
		4'd7, 4'd7, 4'd7, 4'd7, 4'd7, 4'd7,	// 16..21
		4'd8, 4'd8, 4'd8, 4'd8, 4'd8, 4'd8,	// 22..27
		4'd9, 4'd9, 4'd9, 4'd9	// 28..31, bit 9 has no bound
	};

	// last level of the group under mask bits 0..8
	localparam level_t MASK_BOUND [NUM_BOUNDS] = '{
		5'd1, 5'd2, 5'd3, 5'd4, 5'd11, 5'd13, 5'd15, 5'd21, 5'd27
	};

	typedef struct packed {
		logic accept;	// move level from RZ to RP
		logic retire;	// drop highest level in service
		level_t level;
	} intr_cmd_t;

endpackage

/* src/axil_pkg.sv */
// axil_pkg
// AXI4-Lite channel bundles and the register map of the interrupt unit
// only the fields the slave actually looks at are carried

package axil_pkg;

	typedef logic [7:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;

	typedef struct packed {
		logic awvalid;
		axil_addr_t awaddr;
		logic wvalid;
		axil_data_t wdata;
		logic bready;
		logic arvalid;
		axil_addr_t araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		axil_data_t rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	localparam axil_addr_t REG_MASK    = 8'h00;	// RM, r/w
	localparam axil_addr_t REG_REQ_SET = 8'h04;	// RZ read, write 1 to set
	localparam axil_addr_t REG_REQ_CLR = 8'h08;	// write 1 to clear RZ
	localparam axil_addr_t REG_SERVICE = 8'h0c;	// RP, read only
	localparam axil_addr_t REG_VECTOR  = 8'h10;	// last accepted level

	// levels 0..11 and 28..31; channel levels stay hardware only
	localparam axil_data_t SW_SET_MASK = 32'hf000_0fff;

endpackage

/* src/intr_request_reg.sv */
// intr_request_reg
// RZ, the interrupt request register
// external lines go through a two flop synchronizer and a rising edge
// detector, channel requests and software writes set bits directly
// clears come from software or from the accept of a level

`timescale 1ns/1ns

module intr_request_reg import intr_pkg::*, axil_pkg::*; (
	input logic clk,
	input logic rst_n,
	input src_vec_t irq_src,	// async level lines
	input logic chan_valid,
	input chan_t chan_num,
	input logic set_we,
	input logic clr_we,
	input req_vec_t wdata,
	input intr_cmd_t cmd,
	output req_vec_t rz
);

	src_vec_t src_s1;	// first sync stage
	src_vec_t src_s2;	// second sync stage
	src_vec_t src_d;	// previous s2, for edge detect
	src_vec_t src_rise;
	req_vec_t src_set;
	req_vec_t chan_set;
	req_vec_t sw_set;
	req_vec_t rz_clr;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			src_s1 <= '0;
			src_s2 <= '0;
			src_d <= '0;
		end else begin
			src_s1 <= irq_src;
			src_s2 <= src_s1;
			src_d <= src_s2;
		end
	end

	assign src_rise = src_s2 & ~src_d;

	// lines 0..11 -> levels 0..11, lines 12..15 -> levels 28..31
	assign src_set = {src_rise[15:12], 16'd0, src_rise[11:0]};

	// channel c raises level CHAN_BASE + c
	assign chan_set = chan_valid ? (req_vec_t'(1) << (CHAN_BASE + int'(chan_num))) : '0;

	assign sw_set = set_we ? (wdata & SW_SET_MASK) : '0;

	always_comb begin
		rz_clr = clr_we ? wdata : '0;
		if (cmd.accept)
			rz_clr[cmd.level] = 1'b1;	// request goes into service
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			rz <= '0;
		else
			rz <= (rz & ~rz_clr) | src_set | chan_set | sw_set;	// set wins
	end

endmodule

/* src/intr_mask_reg.sv */
// intr_mask_reg
// RM, the 10 bit group mask
// software loads it, an accept clears the groups the new level blocks
// the bits are spread to one enable per level, level 0 always on

`timescale 1ns/1ns

module intr_mask_reg import intr_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic mask_we,
	input mask_t wdata,
	input intr_cmd_t cmd,
	output mask_t mask,
	output req_vec_t level_mask
);

	mask_t blk;	// groups closed by the accepted level

	always_comb begin
		blk = '0;	// bit 9 never closes on accept
		for (int k = 0; k < NUM_BOUNDS; k++)
			blk[k] = cmd.accept && (MASK_BOUND[k] >= cmd.level);
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			mask <= '0;
		else if (mask_we)
			mask <= wdata;	// software write wins
		else
			mask <= mask & ~blk;
	end

	always_comb begin
		for (int l = 0; l < NUM_LEVELS; l++) begin
			if (MASK_GROUP[l] == NO_GROUP)
				level_mask[l] = 1'b1;	// nmi
			else
				level_mask[l] = mask[MASK_GROUP[l]];
		end
	end

endmodule

/* src/intr_priority.sv */
// intr_priority
// RP, the in-service register, and the priority chain
// a request is granted only when it is unmasked, the highest pending
// one, and above every level already in service

`timescale 1ns/1ns

module intr_priority import intr_pkg::*; (
	input logic clk,
	input logic rst_n,
	input req_vec_t rz,
	input req_vec_t level_mask,
	input intr_cmd_t cmd,
	output req_vec_t rp,
	output logic grant_valid,
	output level_t grant_level
);

	req_vec_t pend;	// requests past the mask
	level_t rp_top;	// highest level in service
	logic pend_any;
	logic rp_any;

	// lowest set index, the chain walks from level 0 down
	function automatic level_t first_set(input req_vec_t v);
		level_t idx;
		idx = '0;
		for (int i = NUM_LEVELS - 1; i >= 0; i--) begin
			if (v[i])
				idx = level_t'(i);
		end
		return idx;
	endfunction

	assign pend = rz & level_mask;
	assign pend_any = |pend;
	assign rp_any = |rp;

	assign grant_level = first_set(pend);
	assign rp_top = first_set(rp);

	// strictly above all in service, nothing in service passes anything
	assign grant_valid = pend_any && (!rp_any || (grant_level < rp_top));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rp <= '0;
		end else begin
			if (cmd.retire && rp_any)
				rp[rp_top] <= 1'b0;	// return from interrupt
			if (cmd.accept)
				rp[cmd.level] <= 1'b1;
		end
	end

endmodule

/* src/intr_ctrl.sv */
// intr_ctrl
// Acknowledge and return sequencing toward the CPU
// ack in idle with a live grant latches the level, the next cycle
// commits it to the datapath, then vector_valid pulses once
// ret in idle retires the top in-service level on the next edge

`timescale 1ns/1ns

module intr_ctrl import intr_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic ack,
	input logic ret,
	input logic grant_valid,
	input level_t grant_level,
	output intr_cmd_t cmd,
	output logic irq,
	output logic vector_valid,
	output level_t vector
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_LATCH,	// level held, accept on the way out
		S_COMMIT	// datapath updated, vector out
	} state_t;

	state_t state;
	level_t lvl_q;	// level taken at ack
	level_t vec_q;	// last accepted, for readback
	logic take_ack;

	assign take_ack = (state == S_IDLE) && ack && grant_valid;	// stray ack dropped

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
			irq <= 1'b0;
			vec_q <= '0;
		end else begin
			irq <= grant_valid;	// one cycle behind the chain
			case (state)
				S_IDLE: begin
					if (take_ack)
						state <= S_LATCH;
				end
				S_LATCH: begin
					state <= S_COMMIT;
					vec_q <= lvl_q;	// same edge as the RZ/RP/RM update
				end
				S_COMMIT: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take_ack)
			lvl_q <= grant_level;
	end

	always_comb begin
		cmd.accept = (state == S_LATCH);
		cmd.retire = (state == S_IDLE) && ret;	// acts on the sampling edge
		cmd.level = lvl_q;
	end

	assign vector_valid = (state == S_COMMIT);
	assign vector = vec_q;

endmodule

/* src/axil_regs.sv */
// axil_regs
// AXI4-Lite slave for the interrupt unit registers
// one write and one read in flight at most, each answered a cycle
// after it is taken and held until the master takes the response

`timescale 1ns/1ns

module axil_regs import intr_pkg::*, axil_pkg::*; (
	input logic clk,
	input logic rst_n,
	input axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	input mask_t mask,
	input req_vec_t rz,
	input req_vec_t rp,
	input level_t vector,
	output logic mask_we,
	output logic set_we,
	output logic clr_we,
	output req_vec_t wdata
);

	logic aw_take;	// write accepted this cycle
	logic ar_take;	// read accepted this cycle
	logic bvalid;
	logic rvalid;
	logic [1:0] bresp;
	logic [1:0] rresp;
	axil_data_t rdata;
	axil_data_t rd_mux;

	function automatic logic addr_ok(input axil_addr_t a);
		case (a)
			REG_MASK, REG_REQ_SET, REG_REQ_CLR, REG_SERVICE, REG_VECTOR: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	assign aw_take = axil_req.awvalid && axil_req.wvalid && !bvalid;
	assign ar_take = axil_req.arvalid && !rvalid;

	// strobes line up with the accept edge
	assign mask_we = aw_take && (axil_req.awaddr == REG_MASK);
	assign set_we = aw_take && (axil_req.awaddr == REG_REQ_SET);
	assign clr_we = aw_take && (axil_req.awaddr == REG_REQ_CLR);
	assign wdata = axil_req.wdata;

	always_comb begin
		case (axil_req.araddr)
			REG_MASK: rd_mux = {22'd0, mask};
			REG_REQ_SET: rd_mux = rz;
			REG_SERVICE: rd_mux = rp;
			REG_VECTOR: rd_mux = {27'd0, vector};
			default: rd_mux = '0;	// clr is write only, unmapped reads 0
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (aw_take)
				bvalid <= 1'b1;
			else if (axil_req.bready)
				bvalid <= 1'b0;
			if (ar_take)
				rvalid <= 1'b1;
			else if (axil_req.rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (aw_take)
			bresp <= addr_ok(axil_req.awaddr) ? RESP_OKAY : RESP_SLVERR;
		if (ar_take) begin
			rdata <= rd_mux;
			rresp <= addr_ok(axil_req.araddr) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	always_comb begin
		axil_rsp.awready = aw_take;	// aw and w taken together
		axil_rsp.wready = aw_take;
		axil_rsp.bvalid = bvalid;
		axil_rsp.bresp = bresp;
		axil_rsp.arready = ar_take;
		axil_rsp.rvalid = rvalid;
		axil_rsp.rdata = rdata;
		axil_rsp.rresp = rresp;
	end

endmodule

/* src/intr_unit.sv */
// intr_unit
// Priority interrupt controller, 32 levels under a 10 bit group mask
// control FSM, RZ/RM/RP datapath and the AXI4-Lite register port

`timescale 1ns/1ns

module intr_unit import intr_pkg::*, axil_pkg::*; (
	input logic clk,
	input logic rst_n,
	input src_vec_t irq_src,
	input logic chan_valid,
	input chan_t chan_num,
	input axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	input logic ack,
	input logic ret,
	output logic irq,
	output logic vector_valid,
	output level_t vector
);

	intr_cmd_t cmd;
	logic grant_valid;
	level_t grant_level;
	req_vec_t rz;
	req_vec_t rp;
	mask_t mask;
	req_vec_t level_mask;
	logic mask_we;
	logic set_we;
	logic clr_we;
	req_vec_t wdata;

	intr_ctrl intr_ctrl_i (
		.clk(clk), .rst_n(rst_n), .ack(ack), .ret(ret),
		.grant_valid(grant_valid), .grant_level(grant_level),
		.cmd(cmd), .irq(irq), .vector_valid(vector_valid), .vector(vector)
	);

	intr_request_reg intr_request_reg_i (
		.clk(clk), .rst_n(rst_n), .irq_src(irq_src),
		.chan_valid(chan_valid), .chan_num(chan_num),
		.set_we(set_we), .clr_we(clr_we), .wdata(wdata), .cmd(cmd), .rz(rz)
	);

	intr_mask_reg intr_mask_reg_i (
		.clk(clk), .rst_n(rst_n), .mask_we(mask_we), .wdata(wdata[9:0]),
		.cmd(cmd), .mask(mask), .level_mask(level_mask)
	);

	intr_priority intr_priority_i (
		.clk(clk), .rst_n(rst_n), .rz(rz), .level_mask(level_mask), .cmd(cmd),
		.rp(rp), .grant_valid(grant_valid), .grant_level(grant_level)
	);

	axil_regs axil_regs_i (
		.clk(clk), .rst_n(rst_n), .axil_req(axil_req), .axil_rsp(axil_rsp),
		.mask(mask), .rz(rz), .rp(rp), .vector(vector),
		.mask_we(mask_we), .set_we(set_we), .clr_we(clr_we), .wdata(wdata)
	);

endmodule

/* verif/intr_unit_tb.sv */
// intr_unit_tb
// Directed testbench for the priority interrupt controller
// drives AXI4-Lite register traffic, source lines, channel requests
// and the CPU ack/ret port, and checks RZ, RM, RP and the vector
// against values worked out from the level and mask group rules

`timescale 1ns/1ns

module intr_unit_tb import intr_pkg::*, axil_pkg::*; ();

	logic clk;
	logic rst_n;
	src_vec_t irq_src;
	logic chan_valid;
	chan_t chan_num;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	logic ack;
	logic ret;
	logic irq;
	logic vector_valid;
	level_t vector;

	int errors;
	int ntests;
	int cycles = 0;
	logic [15:0] lfsr;	// random source
	level_t last_vec;	// last level the tests expect accepted
	string cur_test;

	intr_unit intr_unit_i (
		.clk(clk), .rst_n(rst_n), .irq_src(irq_src),
		.chan_valid(chan_valid), .chan_num(chan_num),
		.axil_req(axil_req), .axil_rsp(axil_rsp),
		.ack(ack), .ret(ret), .irq(irq), .vector_valid(vector_valid), .vector(vector)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 8 ns period
	end

	// limit well above the ~600 cycles all tests take
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= 4000) begin
			$display("run stopped, no end after %0d cycles", cycles);
			$display("Something failed");
			$finish;
		end
	end

	// fibonacci taps x^16 + x^14 + x^13 + x^11 + 1
	task automatic rand_bits(input int n, output logic [31:0] v);
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];	// one step per bit
			lfsr = {lfsr[14:0], fb};
			v = {v[30:0], fb};
		end
	endtask

	// lines 12..15 sit at levels 28..31
	function automatic int src_level(input int s);
		return (s < 12) ? s : s + 16;
	endfunction

	function automatic int lowest_set(input logic [31:0] v);
		int r;
		r = -1;
		for (int i = 0; i < 32; i++) begin
			if (r < 0 && v[0])
				r = i;
			v = v >> 1;
		end
		return r;
	endfunction

	// last level of each group under mask bits 0..8
	function automatic int group_last(input int k);
		case (k)
			0: return 1;
			1: return 2;
			2: return 3;
			3: return 4;
			4: return 11;
			5: return 13;
			6: return 15;
			7: return 21;
			default: return 27;
		endcase
	endfunction

	// RM once lvl is accepted
	function automatic logic [9:0] mask_after(input logic [9:0] m, input int lvl);
		logic [9:0] clr;
		clr = '0;
		for (int k = 0; k < 9; k++) begin
			if (group_last(k) >= lvl)
				clr = clr | (10'd1 << k);	// group at or after lvl closes
		end
		return m & ~clr;
	endfunction

	task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
		$display("ERR %s %s expected %h actual %h", cur_test, what, exp, act);
		errors++;
	endtask

	task automatic note_hang(input string what);
		$display("%s: %s", cur_test, what);
		errors++;
	endtask

	task automatic end_test(input int e0);
		ntests++;
		if (errors == e0)
			$display("%s passed", cur_test);
		else
			$display("%s had %0d errors", cur_test, errors - e0);
	endtask

	task automatic axil_write(input axil_addr_t addr, input logic [31:0] data,
			output logic [1:0] resp);
		int n;
		@(negedge clk);
		axil_req.awvalid = 1'b1;
		axil_req.awaddr = addr;
		axil_req.wvalid = 1'b1;
		axil_req.wdata = data;
		axil_req.bready = 1'b1;
		n = 0;
		#1;	// awready settles after the drive
		while (!(axil_rsp.awready && axil_rsp.wready) && n < 16) begin
			@(negedge clk);
			#1;
			n++;
		end
		if (!(axil_rsp.awready && axil_rsp.wready))
			note_hang("write address and data never accepted together");
		@(negedge clk);	// accept edge is behind us
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		n = 0;
		while (!axil_rsp.bvalid && n < 16) begin
			@(negedge clk);
			n++;
		end
		if (!axil_rsp.bvalid)
			note_hang("no write response");
		resp = axil_rsp.bresp;
		@(negedge clk);
		axil_req.bready = 1'b0;
	endtask

	task automatic axil_read(input axil_addr_t addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		@(negedge clk);
		axil_req.arvalid = 1'b1;
		axil_req.araddr = addr;
		axil_req.rready = 1'b1;
		n = 0;
		#1;
		while (!axil_rsp.arready && n < 16) begin
			@(negedge clk);
			#1;
			n++;
		end
		if (!axil_rsp.arready)
			note_hang("read address never accepted");
		@(negedge clk);
		axil_req.arvalid = 1'b0;
		n = 0;
		while (!axil_rsp.rvalid && n < 16) begin
			@(negedge clk);
			n++;
		end
		if (!axil_rsp.rvalid)
			note_hang("no read data");
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(negedge clk);
		axil_req.rready = 1'b0;
	endtask

	task automatic write_ok(input axil_addr_t addr, input logic [31:0] data);
		logic [1:0] resp;
		axil_write(addr, data, resp);
		if (resp != 2'b00)
			mismatch("bresp", 32'd0, {30'd0, resp});
	endtask

	task automatic read_expect(input axil_addr_t addr, input logic [31:0] exp, input string what);
		logic [31:0] d;
		logic [1:0] resp;
		axil_read(addr, d, resp);
		if (resp != 2'b00)
			mismatch({what, " rresp"}, 32'd0, {30'd0, resp});
		if (d != exp)
			mismatch(what, exp, d);
	endtask

	// one cycle ack then watch for vector_valid
	task automatic cpu_ack(input int limit, output bit got, output level_t vec);
		int n;
		@(negedge clk);
		ack = 1'b1;
		@(negedge clk);
		ack = 1'b0;
		got = 1'b0;
		vec = '0;
		n = 0;
		while (!got && n < limit) begin
			if (vector_valid) begin
				got = 1'b1;
				vec = vector;
			end else begin
				@(negedge clk);
				n++;
			end
		end
	endtask

	task automatic cpu_ret();
		@(negedge clk);
		ret = 1'b1;
		@(negedge clk);
		ret = 1'b0;
	endtask

	task automatic wait_irq(input int limit, output bit seen);
		int n;
		n = 0;
		seen = 1'b0;
		while (!seen && n < limit) begin
			@(negedge clk);
			seen = irq;
			n++;
		end
	endtask

	task automatic irq_quiet(input int n, output bit rose);
		rose = 1'b0;
		repeat (n) begin
			@(negedge clk);
			if (irq)
				rose = 1'b1;
		end
	endtask

	task automatic test_mask_reg();
		int e0;
		logic [31:0] r;
		logic [31:0] d;
		logic [1:0] resp;
		cur_test = "mask_reg";
		e0 = errors;
		read_expect(REG_MASK, 32'd0, "rm after reset");
		read_expect(REG_SERVICE, 32'd0, "rp after reset");
		read_expect(REG_REQ_SET, 32'd0, "rz after reset");
		repeat (4) begin
			rand_bits(10, r);
			write_ok(REG_MASK, r);
			read_expect(REG_MASK, r, "rm readback");
		end
		axil_read(8'h20, d, resp);	// hole in the map
		if (resp != 2'b10)
			mismatch("unmapped rresp", 32'd2, {30'd0, resp});
		if (d != 32'd0)
			mismatch("unmapped rdata", 32'd0, d);
		axil_write(8'h24, 32'd1, resp);
		if (resp != 2'b10)
			mismatch("unmapped bresp", 32'd2, {30'd0, resp});
		write_ok(REG_MASK, 32'd0);
		end_test(e0);
	endtask

	task automatic test_sw_req();
		int e0;
		logic [31:0] r;
		logic [31:0] exp;
		cur_test = "sw_req";
		e0 = errors;
		exp = '0;
		repeat (4) begin
			rand_bits(32, r);
			write_ok(REG_REQ_SET, r);
			exp = exp | (r & 32'hf000_0fff);	// levels 0..11 and 28..31 only
			read_expect(REG_REQ_SET, exp, "rz after set");
			rand_bits(32, r);
			write_ok(REG_REQ_CLR, r);
			exp = exp & ~r;
			read_expect(REG_REQ_SET, exp, "rz after clear");
		end
		write_ok(REG_REQ_CLR, 32'hffff_ffff);
		read_expect(REG_REQ_SET, 32'd0, "rz cleared");
		end_test(e0);
	endtask

	task automatic test_src_chan();
		int e0;
		int s;
		int n;
		logic [31:0] r;
		logic [31:0] d;
		logic [1:0] resp;
		cur_test = "src_chan";
		e0 = errors;
		for (int i = 0; i < 4; i++) begin
			rand_bits(4, r);
			s = (i == 0) ? 14 : ((i == 1) ? 3 : int'(r[3:0]));
			@(negedge clk);
			irq_src = 16'd1 << s;
			repeat (2) @(negedge clk);
			irq_src = '0;
			d = '0;
			n = 0;
			while (d == 32'd0 && n < 8) begin	// synchronizer delay
				axil_read(REG_REQ_SET, d, resp);
				n++;
			end
			if (d != (32'd1 << src_level(s)))
				mismatch("rz after source", 32'd1 << src_level(s), d);
			write_ok(REG_REQ_CLR, 32'hffff_ffff);
		end
		repeat (4) begin
			rand_bits(4, r);
			@(negedge clk);
			chan_valid = 1'b1;
			chan_num = r[3:0];
			@(negedge clk);
			chan_valid = 1'b0;
			read_expect(REG_REQ_SET, 32'd1 << (12 + int'(r[3:0])), "rz after channel");
			write_ok(REG_REQ_CLR, 32'hffff_ffff);
		end
		end_test(e0);
	endtask

	task automatic test_grant();
		int e0;
		int lvl;
		logic [31:0] r;
		level_t v;
		bit got;
		bit seen;
		cur_test = "grant";
		e0 = errors;
		repeat (2) begin
			write_ok(REG_MASK, 32'h3ff);
			rand_bits(32, r);
			r = (r & 32'hf000_0fff) | 32'h0000_0800;	// level 11 always in
			write_ok(REG_REQ_SET, r);
			lvl = lowest_set(r);
			wait_irq(8, seen);
			if (!seen)
				note_hang("irq never rose");
			cpu_ack(8, got, v);
			last_vec = level_t'(lvl);
			if (!got)
				note_hang("no vector_valid after ack");
			else if (int'(v) != lvl)
				mismatch("vector", 32'(lvl), {27'd0, v});
			read_expect(REG_REQ_SET, r & ~(32'd1 << lvl), "rz after accept");
			read_expect(REG_SERVICE, 32'd1 << lvl, "rp after accept");
			read_expect(REG_MASK, {22'd0, mask_after(10'h3ff, lvl)}, "rm after accept");
			read_expect(REG_VECTOR, 32'(lvl), "vector readback");
			cpu_ret();
			read_expect(REG_SERVICE, 32'd0, "rp after return");
			write_ok(REG_REQ_CLR, 32'hffff_ffff);
		end
		write_ok(REG_MASK, 32'd0);
		end_test(e0);
	endtask

	task automatic test_nest();
		int e0;
		level_t v;
		bit got;
		bit seen;
		cur_test = "nest";
		e0 = errors;
		write_ok(REG_MASK, 32'd0);
		write_ok(REG_REQ_SET, 32'd1 << 5);	// group bit 4 off
		irq_quiet(6, seen);
		if (seen)
			mismatch("irq with level masked", 32'd0, 32'd1);
		write_ok(REG_REQ_SET, 32'd1);	// level 0 ignores RM
		wait_irq(8, seen);
		if (!seen)
			mismatch("irq for level 0", 32'd1, 32'd0);
		cpu_ack(8, got, v);
		last_vec = 5'd0;
		if (!got)
			note_hang("no vector_valid for level 0");
		else if (v != 5'd0)
			mismatch("vector", 32'd0, {27'd0, v});
		write_ok(REG_MASK, 32'h3ff);
		irq_quiet(6, seen);	// level 5 waits behind level 0
		if (seen)
			mismatch("irq under level 0 service", 32'd0, 32'd1);
		cpu_ret();
		wait_irq(8, seen);
		if (!seen)
			mismatch("irq after return", 32'd1, 32'd0);
		cpu_ack(8, got, v);
		last_vec = 5'd5;
		if (!got)
			note_hang("no vector_valid for level 5");
		else if (v != 5'd5)
			mismatch("vector", 32'd5, {27'd0, v});
		read_expect(REG_SERVICE, 32'd1 << 5, "rp nested");
		cpu_ret();
		read_expect(REG_SERVICE, 32'd0, "rp after return");
		read_expect(REG_REQ_SET, 32'd0, "rz empty");
		end_test(e0);
	endtask

	task automatic test_spurious();
		int e0;
		level_t v;
		bit got;
		bit seen;
		cur_test = "spurious";
		e0 = errors;
		write_ok(REG_MASK, 32'h0aa);
		write_ok(REG_REQ_SET, 32'd1 << 3);	// level 3 sits under closed bit 2
		irq_quiet(4, seen);
		if (seen)
			mismatch("irq with level masked", 32'd0, 32'd1);
		cpu_ack(4, got, v);
		if (got)
			mismatch("vector_valid on stray ack", 32'd0, 32'd1);
		read_expect(REG_MASK, 32'h0aa, "rm kept");
		read_expect(REG_REQ_SET, 32'd1 << 3, "rz kept");
		read_expect(REG_SERVICE, 32'd0, "rp kept");
		read_expect(REG_VECTOR, {27'd0, last_vec}, "vector kept");
		write_ok(REG_REQ_CLR, 32'hffff_ffff);
		end_test(e0);
	endtask

	initial begin
		irq_src = '0;
		chan_valid = 1'b0;
		chan_num = '0;
		axil_req = '0;
		ack = 1'b0;
		ret = 1'b0;
		rst_n = 1'b0;
		lfsr = 16'd8259;
		errors = 0;
		ntests = 0;
		last_vec = '0;
		repeat (3) @(negedge clk);	// three reset edges
		rst_n = 1'b1;
		test_mask_reg();
		test_sw_req();
		test_src_chan();
		test_grant();
		test_nest();
		test_spurious();
		$display("%0d tests run, %0d errors", ntests, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* flist.f */
src/intr_pkg.sv
src/axil_pkg.sv
src/intr_request_reg.sv
src/intr_mask_reg.sv
src/intr_priority.sv
src/intr_ctrl.sv
src/axil_regs.sv
src/intr_unit.sv
verif/intr_unit_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module intr_unit_tb -f flist.f
	@out="$$(./obj_dir/Vintr_unit_tb)"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
